/* verilog/pixel_pkg.sv */
// RGB565 pixel types, red in the top five bits and blue in the bottom five, no alpha channel
package pixel_pkg;

	// full pixel width, must match the sum of the three channels
	localparam int PIXEL_W = 16;

	// red channel, five bits
	typedef logic [4:0] red_t;

	// green channel, one bit wider than red and blue
	typedef logic [5:0] green_t;

	// blue channel, five bits
	typedef logic [4:0] blue_t;

	// field order gives the usual RGB565 bit layout
	// red [15:11], green [10:5], blue [4:0]
	typedef struct packed {
		red_t   red;
		green_t green;
		blue_t  blue;
	} pixel_t;

endpackage

/* verilog/frame_pkg.sv */
// Line geometry for a fixed line length of 16 pixels, a power of two so the column index wraps cleanly
package frame_pkg;

	// pixels per line
	localparam int LINE_LEN = 16;

	// column index, wide enough for LINE_LEN entries
	typedef logic [$clog2(LINE_LEN)-1:0] col_t;

	// one vertical slice through three rows
	// top is row r-2, mid is row r-1, bot is the incoming row r
	typedef struct packed {
		pixel_pkg::pixel_t top;
		pixel_pkg::pixel_t mid;
		pixel_pkg::pixel_t bot;
	} column_t;

	// the five taps of the Laplacian cross
	// corners carry zero weight and are not kept
	typedef struct packed {
		pixel_pkg::pixel_t up;
		pixel_pkg::pixel_t left;
		pixel_pkg::pixel_t centre;
		pixel_pkg::pixel_t right;
		pixel_pkg::pixel_t down;
	} window_t;

endpackage

/* verilog/row_store.sv */
// Two line RAMs with one strobe per pixel in raster order, lines of exactly LINE_LEN pixels, no stall
module row_store (
	input  logic               clk,
	input  logic               reset,
	input  logic               pix_valid,
	input  pixel_pkg::pixel_t  pix_in,
	output logic               col_valid,
	output frame_pkg::column_t column,
	output frame_pkg::col_t    col_index,
	output logic               row_ready
);

	// line_1 holds row r-1, line_2 holds row r-2
	pixel_pkg::pixel_t line_1 [frame_pkg::LINE_LEN];
	pixel_pkg::pixel_t line_2 [frame_pkg::LINE_LEN];

	// write position in the current row
	frame_pkg::col_t col_cnt;

	// rows seen so far, saturates at 2
	logic [1:0] row_cnt;

	logic last_col;

	assign last_col = (col_cnt == frame_pkg::col_t'(frame_pkg::LINE_LEN - 1));

	// column and row counters
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			col_cnt <= '0;
			row_cnt <= '0;
		end else if (pix_valid) begin
			if (last_col) begin
				col_cnt <= '0;
				// only need to know that two rows are behind us
				if (row_cnt != 2'd2) begin
					row_cnt <= row_cnt + 2'd1;
				end
			end else begin
				col_cnt <= col_cnt + 1'b1;
			end
		end
	end

	// strobe and position tags, aligned with the RAM read data
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			col_valid <= 1'b0;
			col_index <= '0;
			row_ready <= 1'b0;
		end else begin
			col_valid <= pix_valid;
			if (pix_valid) begin
				col_index <= col_cnt;
				// both line RAMs hold real rows
				row_ready <= (row_cnt == 2'd2);
			end
		end
	end

	// read before write at the same address
	// old r-1 value drops into the r-2 line
	always_ff @(posedge clk) begin
		if (pix_valid) begin
			line_1[col_cnt] <= pix_in;
			line_2[col_cnt] <= line_1[col_cnt];
			column.top      <= line_2[col_cnt];
			column.mid      <= line_1[col_cnt];
			// incoming pixel just rides along with the reads
			column.bot      <= pix_in;
		end
	end

endmodule

/* verilog/stencil_window.sv */
// Centre tap lags the incoming column by one, so the last column of a row never becomes a centre
module stencil_window (
	input  logic               clk,
	input  logic               reset,
	input  logic               col_valid,
	input  frame_pkg::column_t column,
	input  frame_pkg::col_t    col_index,
	input  logic               row_ready,
	output logic               win_valid,
	output frame_pkg::window_t window,
	output logic               border
);

	// column c-1, all three rows
	frame_pkg::column_t prev_col;

	// column c-2, only the middle row is a tap
	pixel_pkg::pixel_t prev2_mid;

	// history shift and tap selection
	// incoming column is the right neighbour of the centre
	always_ff @(posedge clk) begin
		if (col_valid) begin
			prev_col      <= column;
			prev2_mid     <= prev_col.mid;
			window.up     <= prev_col.top;
			window.left   <= prev2_mid;
			window.centre <= prev_col.mid;
			window.right  <= column.mid;
			window.down   <= prev_col.bot;
		end
	end

	// valid once two rows are stored and a centre exists in this row
	// col_index 0 would centre on the previous row's last column
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			win_valid <= 1'b0;
			border    <= 1'b0;
		end else begin
			win_valid <= col_valid && row_ready && (col_index != '0);
			if (col_valid) begin
				// centre sits on column 0, left tap wrapped from the row before
				border <= (col_index == frame_pkg::col_t'(1));
			end
		end
	end

endmodule

/* verilog/channel_kernel.sv */
// Combinational Laplacian for one channel, result wraps modulo the channel width with no clamping
module channel_kernel #(
	parameter type chan_t = logic [4:0]
) (
	input  chan_t up,
	input  chan_t left,
	input  chan_t centre,
	input  chan_t right,
	input  chan_t down,
	output chan_t result
);

	// cross neighbours weigh +1
	chan_t neigh_sum;

	// centre weighs -4, shift drops the top two bits
	chan_t centre_x4;

	assign neigh_sum = chan_t'(up + left + right + down);
	assign centre_x4 = chan_t'(centre << 2);

	// wrap at channel width, same as truncation in the old filter
	assign result = chan_t'(neigh_sum - centre_x4);

endmodule

/* verilog/pixel_pack.sv */
// Output register with no back-pressure, pix_out reads zero on border pixels and whenever out_valid is low
module pixel_pack (
	input  logic              clk,
	input  logic              reset,
	input  logic              win_valid,
	input  logic              border,
	input  pixel_pkg::red_t   red,
	input  pixel_pkg::green_t green,
	input  pixel_pkg::blue_t  blue,
	output logic              out_valid,
	output pixel_pkg::pixel_t pix_out
);

	// channels joined in RGB565 order
	logic [pixel_pkg::PIXEL_W-1:0] packed_pix;

	// border centre is forced black
	assign packed_pix = border ? '0 : {red, green, blue};

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			out_valid <= 1'b0;
			pix_out   <= '0;
		end else begin
			out_valid <= win_valid;
			// idle cycles drive zero so the bus is quiet
			if (win_valid) begin
				pix_out <= pixel_pkg::pixel_t'(packed_pix);
			end else begin
				pix_out <= '0;
			end
		end
	end

endmodule

/* verilog/laplace_filter.sv */
// Streaming 3x3 Laplacian on RGB565, three cycles from input strobe to output, consumer must take every out_valid
module laplace_filter (
	input  logic              clk,
	input  logic              reset,
	input  logic              pix_valid,
	input  pixel_pkg::pixel_t pix_in,
	output logic              out_valid,
	output pixel_pkg::pixel_t pix_out
);

	logic               col_valid;
	frame_pkg::column_t column;
	frame_pkg::col_t    col_index;
	logic               row_ready;

	logic               win_valid;
	frame_pkg::window_t window;
	logic               border;

	pixel_pkg::red_t    red_res;
	pixel_pkg::green_t  green_res;
	pixel_pkg::blue_t   blue_res;

	// line buffers, one column out per pixel in
	row_store i_row_store (
		.clk       (clk),
		.reset     (reset),
		.pix_valid (pix_valid),
		.pix_in    (pix_in),
		.col_valid (col_valid),
		.column    (column),
		.col_index (col_index),
		.row_ready (row_ready)
	);

	// cross-shaped taps plus border flag
	stencil_window i_stencil_window (
		.clk       (clk),
		.reset     (reset),
		.col_valid (col_valid),
		.column    (column),
		.col_index (col_index),
		.row_ready (row_ready),
		.win_valid (win_valid),
		.window    (window),
		.border    (border)
	);

	// one kernel per colour channel
	channel_kernel #(.chan_t(pixel_pkg::red_t)) i_red_kernel (
		.up     (window.up.red),
		.left   (window.left.red),
		.centre (window.centre.red),
		.right  (window.right.red),
		.down   (window.down.red),
		.result (red_res)
	);

	// green is six bits, wraps at 64
	channel_kernel #(.chan_t(pixel_pkg::green_t)) i_green_kernel (
		.up     (window.up.green),
		.left   (window.left.green),
		.centre (window.centre.green),
		.right  (window.right.green),
		.down   (window.down.green),
		.result (green_res)
	);

	channel_kernel #(.chan_t(pixel_pkg::blue_t)) i_blue_kernel (
		.up     (window.up.blue),
		.left   (window.left.blue),
		.centre (window.centre.blue),
		.right  (window.right.blue),
		.down   (window.down.blue),
		.result (blue_res)
	);

	// output register
	pixel_pack i_pixel_pack (
		.clk       (clk),
		.reset     (reset),
		.win_valid (win_valid),
		.border    (border),
		.red       (red_res),
		.green     (green_res),
		.blue      (blue_res),
		.out_valid (out_valid),
		.pix_out   (pix_out)
	);

endmodule

/* test/laplace_filter_assertions.sv */
// Watches only the top-level strobes, relies on the fixed three-edge depth of the pipeline
module laplace_filter_assertions (
	input logic              clk,
	input logic              reset,
	input logic              pix_valid,
	input logic              out_valid,
	input pixel_pkg::pixel_t pix_out
);
	timeunit 1ns;
	timeprecision 1ns;

	// quiet while reset is held
	assert property (@(posedge clk) reset |-> !out_valid)
		else $error("out_valid high during reset");

	// and in the first cycle after release
	assert property (@(posedge clk) $fell(reset) |=> !out_valid)
		else $error("out_valid high in the cycle after reset");

	// back to back outputs need back to back inputs three edges earlier
	assert property (@(posedge clk) disable iff (reset)
		out_valid && $past(out_valid) |-> $past(pix_valid, 3) && $past(pix_valid, 4))
		else $error("two outputs in a row without two source strobes");

	// idle bus reads zero
	assert property (@(posedge clk) !out_valid |-> pix_out == '0)
		else $error("pix_out not zero while out_valid is low");

endmodule

bind laplace_filter laplace_filter_assertions i_assertions (
	.clk       (clk),
	.reset     (reset),
	.pix_valid (pix_valid),
	.out_valid (out_valid),
	.pix_out   (pix_out)
);

/* test/laplace_filter_tb.sv */
// Every frame starts after a reset because the DUT has no frame start, and frames are at most 6 rows
module laplace_filter_tb;
	timeunit 1ns;
	timeprecision 1ns;

	localparam int W = frame_pkg::LINE_LEN;
	localparam int MAX_ROWS = 6;
	localparam int PERIOD = 100;
	// edges from pix_valid sampled to out_valid sampled
	localparam int LATENCY = 3;
	localparam int TIMEOUT = 20;

	// expected pixel and the edge it must show up at
	typedef struct packed {
		pixel_pkg::pixel_t pix;
		logic [63:0]       due;
	} expect_t;

	logic              clk = 1'b0;
	logic              reset;
	logic              pix_valid;
	pixel_pkg::pixel_t pix_in;
	logic              out_valid;
	pixel_pkg::pixel_t pix_out;

	// stimulus frame, the model reads it too
	pixel_pkg::pixel_t frame [MAX_ROWS][W];
	expect_t           expect_q [$];
	expect_t           head;
	int                errors = 0;
	int                timeouts = 0;
	int                outputs = 0;

	laplace_filter i_dut (
		.clk       (clk),
		.reset     (reset),
		.pix_valid (pix_valid),
		.pix_in    (pix_in),
		.out_valid (out_valid),
		.pix_out   (pix_out)
	);

	always #(PERIOD / 2) clk = ~clk;

	// outputs checked in order, value and arrival edge
	always @(posedge clk) begin
		if (!reset && out_valid) begin
			outputs++;
			assert (expect_q.size() != 0) else begin
				errors++;
				$display("output at %0t arrived while no pixel was expected", $time);
			end
			if (expect_q.size() != 0) begin
				head = expect_q.pop_front();
				assert (pix_out == head.pix) else begin
					errors++;
					$display("** Error at %0t: pix_out %h, expected %h", $time, pix_out, head.pix);
				end
				assert ($time == head.due) else begin
					errors++;
					$display("** Error at %0t: output was due at %0t", $time, head.due);
				end
			end
		end
	end

	// cross of +1 taps minus 4 x centre, each channel cut to its own width
	function automatic pixel_pkg::pixel_t model_pixel(input int r, input int c);
		pixel_pkg::pixel_t u;
		pixel_pkg::pixel_t l;
		pixel_pkg::pixel_t m;
		pixel_pkg::pixel_t rt;
		pixel_pkg::pixel_t d;
		pixel_pkg::pixel_t p;
		// column 0 lies outside the middle of the line
		if (c == 0) begin
			return '0;
		end
		u = frame[r - 1][c];
		d = frame[r + 1][c];
		l = frame[r][c - 1];
		rt = frame[r][c + 1];
		m = frame[r][c];
		p.red = pixel_pkg::red_t'(u.red + l.red + rt.red + d.red - 4 * m.red);
		p.green = pixel_pkg::green_t'(u.green + l.green + rt.green + d.green - 4 * m.green);
		p.blue = pixel_pkg::blue_t'(u.blue + l.blue + rt.blue + d.blue - 4 * m.blue);
		return p;
	endfunction

	// kind 0 constant, 1 address pattern, else random
	task automatic fill_frame(input int kind, input logic [15:0] value);
		for (int r = 0; r < MAX_ROWS; r++) begin
			for (int c = 0; c < W; c++) begin
				if (kind == 0) begin
					frame[r][c] = value;
				end else if (kind == 1) begin
					frame[r][c] = 16'((r * W + c) * 40503 + 7);
				end else begin
					frame[r][c] = 16'($urandom);
				end
			end
		end
	endtask

	// pending expectations die with the pipeline
	task automatic apply_reset(input int cycles);
		@(posedge clk);
		#1;
		reset = 1'b1;
		pix_valid = 1'b0;
		expect_q.delete();
		repeat (cycles) @(posedge clk);
		#1;
		reset = 1'b0;
	endtask

	// raster stream, a centre is queued once its lower right neighbour goes in
	task automatic send_frame(input int rows, input int max_gap, input int limit);
		int      sent;
		expect_t e;
		sent = 0;
		for (int r = 0; r < rows; r++) begin
			for (int c = 0; c < W && sent < limit; c++) begin
				@(posedge clk);
				#1;
				pix_valid = 1'b1;
				pix_in = frame[r][c];
				sent++;
				if (r >= 2 && c >= 1) begin
					e.pix = model_pixel(r - 1, c - 1);
					// sampled one delay short of the next edge
					e.due = $time - 1 + (LATENCY + 1) * PERIOD;
					expect_q.push_back(e);
				end
				repeat ($urandom_range(max_gap, 0)) begin
					@(posedge clk);
					#1;
					pix_valid = 1'b0;
				end
			end
		end
		@(posedge clk);
		#1;
		pix_valid = 1'b0;
	endtask

	// bounded wait for the queue, then idle edges to catch strays
	task automatic drain(input string name);
		int n;
		n = 0;
		while (expect_q.size() != 0 && n < TIMEOUT) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (expect_q.size() != 0) begin
			timeouts++;
			$display("%s timed out with %0d pixels never output", name, expect_q.size());
		end
		repeat (4) @(posedge clk);
	endtask

	task automatic run_frame(input string name, input int rows, input int max_gap);
		apply_reset(4);
		send_frame(rows, max_gap, rows * W);
		drain(name);
	endtask

	// no edges in a flat image, two output rows
	task automatic flat_frame();
		int first;
		fill_frame(0, 16'h5a6b);
		first = outputs;
		run_frame("flat frame", 4, 0);
		assert (outputs - first == 2 * (W - 1)) else begin
			errors++;
			$display("** Error at %0t: flat frame gave %0d outputs, expected %0d",
				$time, outputs - first, 2 * (W - 1));
		end
	endtask

	// white dot, all four neighbours are centres too
	task automatic single_dot();
		fill_frame(0, 16'h0000);
		frame[2][5] = 16'hffff;
		run_frame("single dot", 5, 0);
	endtask

	task automatic border_column();
		fill_frame(1, 16'h0000);
		run_frame("border column", 4, 0);
	endtask

	// back to back, arrival edge checked by the monitor
	task automatic latency_back_to_back();
		fill_frame(2, 16'h0000);
		run_frame("latency", 4, 0);
	endtask

	task automatic random_gaps();
		fill_frame(2, 16'h0000);
		run_frame("random gaps", MAX_ROWS, 3);
	endtask

	// reset inside row 2, then a fresh frame from row 0
	task automatic reset_mid_frame();
		fill_frame(2, 16'h0000);
		apply_reset(4);
		send_frame(3, 1, 2 * W + 7);
		apply_reset(4);
		fill_frame(2, 16'h0000);
		send_frame(4, 1, 4 * W);
		drain("reset mid frame");
	endtask

	initial begin
		reset = 1'b1;
		pix_valid = 1'b0;
		pix_in = '0;
		void'($urandom(32'hbffe));
		flat_frame();
		single_dot();
		border_column();
		latency_back_to_back();
		random_gaps();
		reset_mid_frame();
		$display("outputs %0d, errors %0d, timeouts %0d", outputs, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* src.f */
verilog/pixel_pkg.sv
verilog/frame_pkg.sv
verilog/row_store.sv
verilog/stencil_window.sv
verilog/channel_kernel.sv
verilog/pixel_pack.sv
verilog/laplace_filter.sv
test/laplace_filter_assertions.sv
test/laplace_filter_tb.sv

/* Makefile */
TOP = laplace_filter_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check $(LOG)"
	@echo "make clean  remove obj_dir and $(LOG)"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ns -f src.f \
		--top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
		if [ $$status -ne 0 ] || grep -q "RESULT: FAIL" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
